// ==== testbench/axis_cdc_stim.txt ====
// digits from the left are mode then tlast then tuser then two of tdata
// mode 0 ready always, mode 1 ready random, mode 2 output stalled for 60 cycles
00010
00111
01012
00120
01021
01130
10040
10041
10042
11043
11050
20060
20061
20062
20063
20064
20065
20066
20067
20068
20069
2006a
2106b
00170
00071
01072
00080
00081
00082
00083
00084
01085

// ==== compile.f ====
common/axis_cdc_pkg.sv
axis_async_fifo/axis_async_fifo.sv
rtl/axis_frame_filter.sv
rtl/axis_skid_register.sv
rtl/axis_cdc_filter_top.sv
testbench/tb_clock_gen.sv
testbench/tb_axis_cdc_filter.sv

// ==== run_verilator.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module tb_axis_cdc_filter \
  -Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1

// ==== testbench/tb_axis_cdc_filter.sv ====
`timescale 1ns/1ps

module tb_axis_cdc_filter;

  import axis_cdc_pkg::*;

  localparam int DATA_WIDTH   = DEFAULT_DATA_WIDTH;
  localparam int ADDR_WIDTH   = DEFAULT_ADDR_WIDTH;
  localparam int OUT_PERIOD   = 10;
  localparam int IN_PERIOD    = 14;
  localparam int MAX_BEATS    = 64;
  localparam int STALL_CYCLES = 60;

  localparam logic [3:0] MODE_RANDOM = 4'd1;
  localparam logic [3:0] MODE_STALL  = 4'd2;

  logic                        output_clk;
  logic                        input_clk;
  logic                        output_rst_sync3;
  logic [DATA_WIDTH-1:0]       s_axis_tdata;
  logic                        s_axis_tvalid;
  logic                        s_axis_tready;
  logic                        s_axis_tlast;
  logic                        s_axis_tuser;
  logic [DATA_WIDTH-1:0]       m_axis_tdata;
  logic                        m_axis_tvalid;
  logic                        m_axis_tready;
  logic                        m_axis_tlast;
  logic [DROP_COUNT_WIDTH-1:0] drop_count;

  // mode nibble, tlast nibble, tuser nibble, tdata byte.
  logic [19:0]         stim_mem [0:MAX_BEATS-1];
  logic [19:0]         beat;
  logic [DATA_WIDTH:0] exp_q [$];

  int         num_beats;
  int         beat_idx;
  int         wait_count;
  int         exp_drops = 0;
  int         value_errors = 0;
  int         other_errors = 0;
  int         watchdog_ns = 0;
  int         stall_requests = 0;
  int         stall_seen = 0;
  int         stalls_taken = 0;
  int         stall_left = 0;
  integer     seed = 32'h89fb9e01;
  integer     rnd;
  logic [3:0] writer_mode = 4'd0;
  logic [3:0] mode_seen = 4'd0;
  logic       first_beat;
  logic       frame_bad;
  logic       full_seen = 1'b0;

  tb_clock_gen #(.PERIOD_NS(OUT_PERIOD)) out_clock0 (.clk(output_clk));
  tb_clock_gen #(.PERIOD_NS(IN_PERIOD)) in_clock0 (.clk(input_clk));

  axis_cdc_filter_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) dut0 (
    .input_clk        (input_clk),
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .s_axis_tdata     (s_axis_tdata),
    .s_axis_tvalid    (s_axis_tvalid),
    .s_axis_tready    (s_axis_tready),
    .s_axis_tlast     (s_axis_tlast),
    .s_axis_tuser     (s_axis_tuser),
    .m_axis_tdata     (m_axis_tdata),
    .m_axis_tvalid    (m_axis_tvalid),
    .m_axis_tready    (m_axis_tready),
    .m_axis_tlast     (m_axis_tlast),
    .drop_count       (drop_count)
  );

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("error %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic note_failure(input string what);
    other_errors++;
    $display("failure: %s", what);
  endtask

  task automatic check_reset_outputs();
    compare_value("m_axis_tvalid", 32'h0, 32'(m_axis_tvalid));
    compare_value("s_axis_tready", 32'h0, 32'(s_axis_tready));
    compare_value("drop_count", 32'h0, 32'(drop_count));
  endtask

  task automatic check_output_beat();
    logic [DATA_WIDTH:0] expected;
    if (exp_q.size() == 0) begin
      note_failure($sformatf("output beat 0x%0h came when no beat was expected", m_axis_tdata));
    end else begin
      expected = exp_q.pop_front();
      compare_value("m_axis_tdata", 32'(expected[DATA_WIDTH-1:0]), 32'(m_axis_tdata));
      compare_value("m_axis_tlast", 32'(expected[DATA_WIDTH]), 32'(m_axis_tlast));
    end
  endtask

  // writer state crosses here, away from its own edges.
  always @(posedge output_clk) begin
    mode_seen  = writer_mode;
    stall_seen = stall_requests;
  end

  // ready for the next rising edge, then check what that edge takes.
  always @(negedge output_clk) begin
    if (stall_seen != stalls_taken) begin
      stalls_taken = stall_seen;
      stall_left   = STALL_CYCLES;
    end
    if (stall_left > 0) begin
      m_axis_tready = 1'b0;
      stall_left--;
    end else if (mode_seen == MODE_RANDOM) begin
      rnd = $random(seed);
      m_axis_tready = rnd[0];
    end else begin
      m_axis_tready = 1'b1;
    end
    if (m_axis_tvalid && m_axis_tready) check_output_beat();
  end

  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("timeout after %0d ns with %0d beats still expected", watchdog_ns, exp_q.size());
    $display("test failed");
    $finish;
  end

  initial begin
    output_rst_sync3 = 1'b1;
    s_axis_tdata     = '0;
    s_axis_tvalid    = 1'b0;
    s_axis_tlast     = 1'b0;
    s_axis_tuser     = 1'b0;
    m_axis_tready    = 1'b0;
    for (beat_idx = 0; beat_idx < MAX_BEATS; beat_idx++) begin
      stim_mem[beat_idx] = '1; // mode f ends the list.
    end
    $readmemh("testbench/axis_cdc_stim.txt", stim_mem);
    num_beats = 0;
    while (num_beats < MAX_BEATS && stim_mem[num_beats][19:16] != 4'hf) begin
      num_beats++;
    end
    watchdog_ns = num_beats * 40 * OUT_PERIOD + 2000;
    if (num_beats == 0) note_failure("the stimulus file holds no beats");

    @(posedge output_clk); // first rising edge applies the reset.
    repeat (8) begin
      @(negedge output_clk);
      check_reset_outputs();
    end
    output_rst_sync3 = 1'b0;
    // write side still in its reset chain.
    repeat (2) begin
      @(negedge output_clk);
      check_reset_outputs();
    end
    wait_count = 0;
    while (!s_axis_tready && wait_count < 10) begin
      @(negedge input_clk);
      wait_count++;
    end
    if (!s_axis_tready) note_failure("s_axis_tready did not rise after the write reset");

    first_beat = 1'b1;
    frame_bad  = 1'b0;
    for (beat_idx = 0; beat_idx < num_beats; beat_idx++) begin
      @(negedge input_clk);
      beat = stim_mem[beat_idx];
      if (first_beat) begin
        writer_mode = beat[19:16];
        frame_bad   = beat[8];
        if (writer_mode == MODE_STALL) stall_requests++;
      end
      s_axis_tdata  = beat[7:0];
      s_axis_tlast  = beat[12];
      s_axis_tuser  = beat[8];
      s_axis_tvalid = 1'b1;
      while (!s_axis_tready) begin
        if (stall_requests > 0) full_seen = 1'b1;
        @(negedge input_clk);
      end
      // taken on the coming rising edge.
      if (!frame_bad) exp_q.push_back({beat[12], beat[7:0]});
      if (beat[12] && frame_bad) exp_drops++;
      first_beat = beat[12];
    end
    @(negedge input_clk);
    s_axis_tvalid = 1'b0;

    while (exp_q.size() != 0) @(negedge output_clk);
    repeat (20) @(negedge output_clk); // stray beats would show here.

    compare_value("drop_count", 32'(exp_drops), 32'(drop_count));
    if (!full_seen) note_failure("s_axis_tready never fell while the output was stalled");
    if (dut0.filter0.state != FILTER_IDLE) begin
      note_failure($sformatf("filter left in state %s", dut0.filter0.state.name()));
    end

    $display("%0d value errors, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk
);

  // free running, starts low.
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

// ==== rtl/axis_cdc_filter_top.sv ====
`timescale 1ns/1ps

module axis_cdc_filter_top #(
  parameter int DATA_WIDTH = axis_cdc_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = axis_cdc_pkg::DEFAULT_ADDR_WIDTH
) (
  input  logic                                   input_clk,
  input  logic                                   output_clk,
  input  logic                                   output_rst_sync3,

  input  logic [DATA_WIDTH-1:0]                  s_axis_tdata,
  input  logic                                   s_axis_tvalid,
  output logic                                   s_axis_tready,
  input  logic                                   s_axis_tlast,
  input  logic                                   s_axis_tuser,

  output logic [DATA_WIDTH-1:0]                  m_axis_tdata,
  output logic                                   m_axis_tvalid,
  input  logic                                   m_axis_tready,
  output logic                                   m_axis_tlast,

  output logic [axis_cdc_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);

  // fifo read side to filter.
  logic [DATA_WIDTH-1:0] fifo_tdata;
  logic                  fifo_tvalid;
  logic                  fifo_tready;
  logic                  fifo_tlast;
  logic                  fifo_tuser;

  // filter to output register.
  logic [DATA_WIDTH-1:0] filt_tdata;
  logic                  filt_tvalid;
  logic                  filt_tready;
  logic                  filt_tlast;

  axis_async_fifo #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) fifo0 (
    .input_clk        (input_clk),
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .s_axis_tdata     (s_axis_tdata),
    .s_axis_tvalid    (s_axis_tvalid),
    .s_axis_tready    (s_axis_tready),
    .s_axis_tlast     (s_axis_tlast),
    .s_axis_tuser     (s_axis_tuser),
    .m_axis_tdata     (fifo_tdata),
    .m_axis_tvalid    (fifo_tvalid),
    .m_axis_tready    (fifo_tready),
    .m_axis_tlast     (fifo_tlast),
    .m_axis_tuser     (fifo_tuser)
  );

  axis_frame_filter #(
    .DATA_WIDTH (DATA_WIDTH)
  ) filter0 (
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .s_tdata          (fifo_tdata),
    .s_tvalid         (fifo_tvalid),
    .s_tready         (fifo_tready),
    .s_tlast          (fifo_tlast),
    .s_tuser          (fifo_tuser),
    .m_tdata          (filt_tdata),
    .m_tvalid         (filt_tvalid),
    .m_tready         (filt_tready),
    .m_tlast          (filt_tlast),
    .drop_count       (drop_count)
  );

  axis_skid_register #(
    .DATA_WIDTH (DATA_WIDTH)
  ) skid0 (
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .s_tdata          (filt_tdata),
    .s_tvalid         (filt_tvalid),
    .s_tready         (filt_tready),
    .s_tlast          (filt_tlast),
    .m_tdata          (m_axis_tdata),
    .m_tvalid         (m_axis_tvalid),
    .m_tready         (m_axis_tready),
    .m_tlast          (m_axis_tlast)
  );

endmodule

// ==== rtl/axis_skid_register.sv ====
`timescale 1ns/1ps

module axis_skid_register #(
  parameter int DATA_WIDTH = axis_cdc_pkg::DEFAULT_DATA_WIDTH
) (
  input  logic                  output_clk,
  input  logic                  output_rst_sync3,

  input  logic [DATA_WIDTH-1:0] s_tdata,
  input  logic                  s_tvalid,
  output logic                  s_tready,
  input  logic                  s_tlast,

  output logic [DATA_WIDTH-1:0] m_tdata,
  output logic                  m_tvalid,
  input  logic                  m_tready,
  output logic                  m_tlast
);

  logic [DATA_WIDTH-1:0] skid_data;
  logic                  skid_last;
  logic                  skid_valid;
  logic                  s_accept;
  logic                  main_load;

  // ready comes straight from a flop.
  assign s_tready  = !skid_valid;
  assign s_accept  = s_tvalid && s_tready;
  assign main_load = !m_tvalid || m_tready; // main register free this cycle.

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      m_tvalid   <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      if (skid_valid) begin
        m_tvalid   <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        m_tvalid <= s_accept;
      end
    end else if (s_accept) begin
      skid_valid <= 1'b1; // stalled, park the beat.
    end
  end

  always_ff @(posedge output_clk) begin
    if (main_load) begin
      if (skid_valid) begin
        m_tdata <= skid_data;
        m_tlast <= skid_last;
      end else if (s_accept) begin
        m_tdata <= s_tdata;
        m_tlast <= s_tlast;
      end
    end else if (s_accept) begin
      skid_data <= s_tdata;
      skid_last <= s_tlast;
    end
  end

  // occupancy changes only by the beats taken in and sent out.
  a_no_loss: assert property (@(posedge output_clk) disable iff (output_rst_sync3)
    1'b1 |=> 3'(m_tvalid) + 3'(skid_valid) ==
      $past(3'(m_tvalid) + 3'(skid_valid) + 3'(s_accept) - 3'(m_tvalid && m_tready)))
    else $error("skid register lost a beat");

endmodule

// ==== rtl/axis_frame_filter.sv ====
`timescale 1ns/1ps

module axis_frame_filter #(
  parameter int DATA_WIDTH = axis_cdc_pkg::DEFAULT_DATA_WIDTH
) (
  input  logic                                   output_clk,
  input  logic                                   output_rst_sync3,

  input  logic [DATA_WIDTH-1:0]                  s_tdata,
  input  logic                                   s_tvalid,
  output logic                                   s_tready,
  input  logic                                   s_tlast,
  input  logic                                   s_tuser,

  output logic [DATA_WIDTH-1:0]                  m_tdata,
  output logic                                   m_tvalid,
  input  logic                                   m_tready,
  output logic                                   m_tlast,

  output logic [axis_cdc_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);

  import axis_cdc_pkg::*;

  localparam logic [DROP_COUNT_WIDTH-1:0] DROP_COUNT_MAX = '1;

  filter_state_t state;
  filter_state_t state_next;
  logic          accept;
  logic          drop_start;

  assign m_tdata = s_tdata;
  assign m_tlast = s_tlast;
  assign accept  = s_tvalid && s_tready;

  // first beat of a bad frame.
  assign drop_start = accept && (state == FILTER_IDLE) && s_tuser;

  always_comb begin
    state_next = state;
    m_tvalid   = 1'b0;
    s_tready   = 1'b0;
    case (state)
      FILTER_IDLE: begin
        m_tvalid = s_tvalid && !s_tuser;
        s_tready = s_tuser || m_tready; // bad first beat is swallowed.
        if (accept && !s_tlast) begin
          state_next = s_tuser ? FILTER_DROP : FILTER_PASS;
        end
      end
      FILTER_PASS: begin
        m_tvalid = s_tvalid;
        s_tready = m_tready;
        if (accept && s_tlast) state_next = FILTER_IDLE;
      end
      FILTER_DROP: begin
        s_tready = 1'b1; // drain regardless of output.
        if (accept && s_tlast) state_next = FILTER_IDLE;
      end
      default: state_next = FILTER_IDLE;
    endcase
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      state      <= FILTER_IDLE;
      drop_count <= '0;
    end else begin
      state <= state_next;
      if (drop_start && drop_count != DROP_COUNT_MAX) begin
        drop_count <= drop_count + 1'b1; // saturates.
      end
    end
  end

  // a dropping frame was counted on entry.
  a_drop_silent: assert property (@(posedge output_clk) disable iff (output_rst_sync3)
    state == FILTER_DROP |-> !m_tvalid && drop_count != '0)
    else $error("filter output active in state %s", state.name());

endmodule

// ==== axis_async_fifo/axis_async_fifo.sv ====
`timescale 1ns/1ps

module axis_async_fifo #(
  parameter int DATA_WIDTH = axis_cdc_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDR_WIDTH = axis_cdc_pkg::DEFAULT_ADDR_WIDTH
) (
  input  logic                  input_clk,
  input  logic                  output_clk,
  input  logic                  output_rst_sync3,

  input  logic [DATA_WIDTH-1:0] s_axis_tdata,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic                  s_axis_tlast,
  input  logic                  s_axis_tuser,

  output logic [DATA_WIDTH-1:0] m_axis_tdata,
  output logic                  m_axis_tvalid,
  input  logic                  m_axis_tready,
  output logic                  m_axis_tlast,
  output logic                  m_axis_tuser
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // write side reset chain, powers up asserted.
  logic input_rst_sync1 = 1'b1;
  logic input_rst_sync2 = 1'b1;
  logic input_rst_sync3 = 1'b1;

  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] wr_ptr_next;
  logic [ADDR_WIDTH:0] wr_ptr_gray;
  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] rd_ptr_next;
  logic [ADDR_WIDTH:0] rd_ptr_gray;

  logic [ADDR_WIDTH:0] wr_ptr_gray_sync1;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync2;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync1;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync2;

  logic [ADDR_WIDTH:0] rd_ptr_sync_bin;
  logic [ADDR_WIDTH:0] wr_fill;

  // tlast, tuser, tdata.
  logic [DATA_WIDTH+1:0] mem [DEPTH];
  logic [DATA_WIDTH+1:0] data_in;
  logic [DATA_WIDTH+1:0] data_out_reg;

  logic full;
  logic empty;
  logic write;
  logic read;

  function automatic logic [ADDR_WIDTH:0] gray2bin(input logic [ADDR_WIDTH:0] gray);
    logic [ADDR_WIDTH:0] bin;
    bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // output reset must be seen low for three input_clk edges.
  always_ff @(posedge input_clk) begin
    input_rst_sync1 <= output_rst_sync3;
    input_rst_sync2 <= input_rst_sync1;
    input_rst_sync3 <= input_rst_sync2;
  end

  assign data_in = {s_axis_tlast, s_axis_tuser, s_axis_tdata};

  // full when the top two gray bits differ and the rest match.
  assign full = wr_ptr_gray == {~rd_ptr_gray_sync2[ADDR_WIDTH:ADDR_WIDTH-1],
                                rd_ptr_gray_sync2[ADDR_WIDTH-2:0]};
  assign empty = rd_ptr_gray == wr_ptr_gray_sync2;

  assign s_axis_tready = !full && !input_rst_sync3;
  assign write = s_axis_tvalid && s_axis_tready;

  // fetch a word when the output register is free or being drained.
  assign read = !empty && (m_axis_tready || !m_axis_tvalid);

  assign wr_ptr_next = wr_ptr + 1'b1;
  assign rd_ptr_next = rd_ptr + 1'b1;

  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else if (write) begin
      wr_ptr      <= wr_ptr_next;
      wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
    end
  end

  always_ff @(posedge input_clk) begin
    if (write) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= data_in;
    end
  end

  // read pointer into the write domain.
  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      rd_ptr_gray_sync1 <= '0;
      rd_ptr_gray_sync2 <= '0;
    end else begin
      rd_ptr_gray_sync1 <= rd_ptr_gray;
      rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else if (read) begin
      rd_ptr      <= rd_ptr_next;
      rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
    end
  end

  // write pointer into the read domain.
  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      wr_ptr_gray_sync1 <= '0;
      wr_ptr_gray_sync2 <= '0;
    end else begin
      wr_ptr_gray_sync1 <= wr_ptr_gray;
      wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
    end
  end

  always_ff @(posedge output_clk) begin
    if (read) begin
      data_out_reg <= mem[rd_ptr[ADDR_WIDTH-1:0]];
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      m_axis_tvalid <= 1'b0;
    end else if (m_axis_tready || !m_axis_tvalid) begin
      m_axis_tvalid <= !empty;
    end
  end

  assign {m_axis_tlast, m_axis_tuser, m_axis_tdata} = data_out_reg;

  // fill level as the write side sees it.
  assign rd_ptr_sync_bin = gray2bin(rd_ptr_gray_sync2);
  assign wr_fill = wr_ptr - rd_ptr_sync_bin;

  a_no_write_full: assert property (@(posedge input_clk) disable iff (input_rst_sync3)
    write |-> wr_fill < DEPTH)
    else $error("fifo written while full");

  a_out_stable: assert property (@(posedge output_clk) disable iff (output_rst_sync3)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
    else $error("fifo output changed while stalled");

endmodule

// ==== common/axis_cdc_pkg.sv ====
package axis_cdc_pkg;

  // beat width of the stream.
  parameter int DEFAULT_DATA_WIDTH = 8;

  // fifo address width, 16 entries.
  parameter int DEFAULT_ADDR_WIDTH = 4;

  // width of the discarded frame counter.
  parameter int DROP_COUNT_WIDTH = 16;

  // per-frame filter states.
  // idle sits between frames and decides on the first beat.
  typedef enum logic [1:0] {
    FILTER_IDLE = 2'd0,
    FILTER_PASS = 2'd1, // forwarding a good frame.
    FILTER_DROP = 2'd2  // swallowing a bad frame.
  } filter_state_t;

endpackage
